// ==== all.f ====
+incdir+dv
rtl/visit_pkg.sv
rtl/apb_pkg.sv
rtl/bit_ram.sv
rtl/visit_bitmap.sv
rtl/visit_filter.sv
rtl/visit_apb_regs.sv
rtl/visit_top.sv
dv/visit_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module visit_tb -f all.f -o visit_sim
out=$(./obj_dir/visit_sim)
echo "$out"
if echo "$out" | grep -qx "Test completed successfully"; then
    exit 0
else
    exit 1
fi

// ==== dv/visit_tb_table.svh ====
`ifndef VISIT_TB_TABLE_SVH
`define VISIT_TB_TABLE_SVH

// Columns: phase, kind, proc, vtx, expected granted, random gap allowed
// Phase 0 runs after the first clear, phase 1 after the clear during traffic
typedef struct packed {
    logic                                 phase;   // 0 before the second clear, 1 after
    visit_pkg::op_kind_e                  kind;
    logic [visit_pkg::proc_bits-1:0]      proc;
    logic [visit_pkg::vtx_bits-1:0]       vtx;
    logic                                 exp_gnt; // Expected granted bit
    logic                                 gap_ok;  // 0 forces back-to-back issue
} row_t;

localparam int n_rows = 18;

row_t rows [n_rows];

task automatic load_rows();
    rows[0]  = '{1'b0, visit_pkg::op_discover, 4'd1,  10'd5,    1'b1, 1'b1}; // New vertex
    rows[1]  = '{1'b0, visit_pkg::op_discover, 4'd2,  10'd5,    1'b0, 1'b1}; // Already checked
    rows[2]  = '{1'b0, visit_pkg::op_expand,   4'd3,  10'd5,    1'b1, 1'b1};
    rows[3]  = '{1'b0, visit_pkg::op_expand,   4'd4,  10'd5,    1'b0, 1'b1}; // Second pop refused
    rows[4]  = '{1'b0, visit_pkg::op_expand,   4'd1,  10'd7,    1'b1, 1'b1}; // Never checked
    rows[5]  = '{1'b0, visit_pkg::op_discover, 4'd2,  10'd7,    1'b1, 1'b1};
    rows[6]  = '{1'b0, visit_pkg::op_discover, 4'd5,  10'd100,  1'b1, 1'b0}; // Burst on one vertex
    rows[7]  = '{1'b0, visit_pkg::op_discover, 4'd6,  10'd100,  1'b0, 1'b0};
    rows[8]  = '{1'b0, visit_pkg::op_expand,   4'd7,  10'd100,  1'b1, 1'b0};
    rows[9]  = '{1'b0, visit_pkg::op_expand,   4'd8,  10'd100,  1'b0, 1'b0};
    rows[10] = '{1'b0, visit_pkg::op_discover, 4'd9,  10'd101,  1'b1, 1'b0};
    rows[11] = '{1'b0, visit_pkg::op_expand,   4'd10, 10'd101,  1'b1, 1'b0};
    rows[12] = '{1'b0, visit_pkg::op_discover, 4'd11, 10'd101,  1'b0, 1'b0};
    rows[13] = '{1'b0, visit_pkg::op_discover, 4'd12, 10'd1023, 1'b1, 1'b0}; // Top address
    rows[14] = '{1'b0, visit_pkg::op_discover, 4'd13, 10'd1023, 1'b0, 1'b0};
    rows[15] = '{1'b0, visit_pkg::op_expand,   4'd14, 10'd0,    1'b1, 1'b1}; // Bottom address
    rows[16] = '{1'b1, visit_pkg::op_discover, 4'd3,  10'd5,    1'b1, 1'b1}; // Cleared again
    rows[17] = '{1'b1, visit_pkg::op_discover, 4'd4,  10'd5,    1'b0, 1'b1};
endtask

`endif

// ==== dv/visit_tb.sv ====
`default_nettype none

module visit_tb;

    `include "visit_tb_table.svh"

    typedef struct packed {
        visit_pkg::vtx_res_t res;     // Expected result word
        logic [31:0]         acc_cyc; // Edge that accepted the op
    } exp_t;

    logic                clk_in;
    logic                rst_in;
    apb_pkg::apb_req_t   apb_req;
    apb_pkg::apb_rsp_t   apb_rsp;
    logic                op_valid;
    visit_pkg::vtx_op_t  op;
    logic                op_ready;
    logic                res_valid;
    visit_pkg::vtx_res_t res;

    logic [31:0] cyc;                   // Rising edges seen
    int          errors;
    int          checks;
    int          n_grant, n_reject;     // Model counters
    logic        chk_m [visit_pkg::vtx_depth]; // Model bitmaps
    logic        vis_m [visit_pkg::vtx_depth];
    exp_t        exp_q [$];             // Results still owed by the DUT

    visit_top visit_top_inst (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .op_valid  (op_valid),
        .op        (op),
        .op_ready  (op_ready),
        .res_valid (res_valid),
        .res       (res)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    always @(posedge clk_in) cyc <= cyc + 1;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            errors++;
            $display("Fail t=%0t %s expected %0h actual %0h", $time, name, exp, act);
        end
    endtask

    // Two-cycle APB access with the response sampled mid-cycle
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk_in);
        #1 apb_req.penable = 1'b1;
        @(negedge clk_in);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_val("pready", 1, 32'(apb_rsp.pready)); // No wait states expected
        @(posedge clk_in);
        #1 apb_req = '0;
    endtask

    // Grant rule applied to the model in issue order
    task automatic model_apply(input visit_pkg::vtx_op_t o, output logic gnt);
        if (o.kind == visit_pkg::op_discover) begin
            gnt = !chk_m[o.vtx];
            chk_m[o.vtx] = 1'b1;
        end else begin
            gnt = !vis_m[o.vtx];
            vis_m[o.vtx] = 1'b1;
        end
        if (gnt) n_grant++;
        else n_reject++;
    endtask

    task automatic send_op(input visit_pkg::vtx_op_t o, input logic exp_gnt, input logic use_tbl);
        logic gnt;
        exp_t e;
        op_valid = 1'b1;
        op       = o;
        @(negedge clk_in);
        while (!op_ready) @(negedge clk_in); // Held until accepted
        model_apply(o, gnt);
        if (use_tbl) check_val("table granted", 32'(exp_gnt), 32'(gnt));
        e.res     = '{proc: o.proc, vtx: o.vtx, kind: o.kind, granted: gnt};
        e.acc_cyc = cyc + 1;
        exp_q.push_back(e);
        @(posedge clk_in);
        #1 op_valid = 1'b0;
    endtask

    // Wait until every issued op has produced its result
    task automatic wait_results();
        while (exp_q.size() != 0) @(negedge clk_in);
        @(posedge clk_in);
        #1;
    endtask

    // Start a clear and poll status until the sweep is over
    task automatic run_clear(input logic check_busy);
        logic [31:0] rd;
        logic err;
        apb_access(1'b1, apb_pkg::reg_ctrl, 32'h1, rd, err);
        check_val("ctrl pslverr", 0, 32'(err));
        if (check_busy) check_val("op_ready", 0, 32'(op_ready)); // Dropped while busy
        apb_access(1'b0, apb_pkg::reg_status, '0, rd, err);
        if (check_busy) check_val("status busy", 1, 32'(rd[0]));
        while (rd[0]) apb_access(1'b0, apb_pkg::reg_status, '0, rd, err);
        for (int i = 0; i < visit_pkg::vtx_depth; i++) begin
            chk_m[i] = 1'b0;
            vis_m[i] = 1'b0;
        end
        n_grant  = 0;
        n_reject = 0;
    endtask

    task automatic apply_phase(input logic ph);
        int gap;
        for (int i = 0; i < n_rows; i++) begin
            if (rows[i].phase == ph) begin
                gap = rows[i].gap_ok ? ($urandom % 4) : 0;
                repeat (gap) @(posedge clk_in);
                if (gap != 0) #1;
                send_op('{kind: rows[i].kind, proc: rows[i].proc, vtx: rows[i].vtx},
                        rows[i].exp_gnt, 1'b1);
            end
        end
        wait_results();                       // Let results drain
    endtask

    task automatic check_counters();
        logic [31:0] rd;
        logic err;
        apb_access(1'b0, apb_pkg::reg_grant_cnt, '0, rd, err);
        check_val("grant_cnt", n_grant, rd);
        apb_access(1'b0, apb_pkg::reg_reject_cnt, '0, rd, err);
        check_val("reject_cnt", n_reject, rd);
    endtask

    // Result monitor checking in-order match and fixed latency
    always @(negedge clk_in) begin
        exp_t e;
        if (!rst_in && res_valid) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("Result appeared at t=%0t with no op outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_val("res.proc", 32'(e.res.proc), 32'(res.proc));
                check_val("res.vtx", 32'(e.res.vtx), 32'(res.vtx));
                check_val("res.kind", 32'(e.res.kind), 32'(res.kind));
                check_val("res.granted", 32'(e.res.granted), 32'(res.granted));
                check_val("res latency", 3, cyc - e.acc_cyc);
            end
        end
    end

    initial begin
        #((n_rows * 8 + 3 * 1100) * 10);
        $display("Timeout after %0t, DUT stopped responding", $time);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        int          seed;
        seed     = $urandom(74);
        cyc      = '0;
        errors   = 0;
        checks   = 0;
        n_grant  = 0;
        n_reject = 0;
        rst_in   = 1'b1;
        apb_req  = '0;
        op_valid = 1'b0;
        op       = '0;
        load_rows();
        repeat (8) @(posedge clk_in);
        #1 rst_in = 1'b0;
        check_val("op_ready", 1, 32'(op_ready));
        check_val("res_valid", 0, 32'(res_valid));
        run_clear(1'b0);                      // Bitmaps start undefined
        apply_phase(1'b0);
        check_counters();
        apb_access(1'b0, 8'h10, '0, rd, err);
        check_val("pslverr unmapped", 1, 32'(err));
        apb_access(1'b1, apb_pkg::reg_status, 32'h1, rd, err);
        check_val("pslverr ro write", 1, 32'(err));
        send_op('{kind: visit_pkg::op_discover, proc: 4'd15, vtx: 10'd200}, 1'b0, 1'b0);
        run_clear(1'b1);                      // Op above still in flight
        wait_results();
        check_counters();                     // Both read 0 after the clear
        apply_phase(1'b1);
        check_counters();
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/visit_top.sv ====
`default_nettype none

// Visit-state filter, bitmap pipeline plus APB register block
module visit_top (
    input  wire                        clk_in,
    input  wire                        rst_in,
    input  wire apb_pkg::apb_req_t     apb_req,
    output apb_pkg::apb_rsp_t          apb_rsp,
    input  wire                        op_valid,
    input  wire visit_pkg::vtx_op_t    op,
    output logic                       op_ready,
    output logic                       res_valid,
    output visit_pkg::vtx_res_t        res
);

    logic                clear_start;      // Regs to bitmap
    logic                clear_busy;       // Bitmap to regs
    logic                s2_valid;         // Bitmap to filter
    visit_pkg::vtx_op_t  s2_op;
    logic                s2_checked;
    logic                s2_visited;
    visit_pkg::bit_wr_t  chk_wr, vis_wr;   // Filter write-back to bitmap

    visit_bitmap visit_bitmap_inst (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .op_valid    (op_valid),
        .op          (op),
        .op_ready    (op_ready),
        .clear_start (clear_start),
        .clear_busy  (clear_busy),
        .chk_wr      (chk_wr),
        .vis_wr      (vis_wr),
        .s2_valid    (s2_valid),
        .s2_op       (s2_op),
        .s2_checked  (s2_checked),
        .s2_visited  (s2_visited)
    );

    visit_filter visit_filter_inst (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .s2_valid    (s2_valid),
        .s2_op       (s2_op),
        .s2_checked  (s2_checked),
        .s2_visited  (s2_visited),
        .chk_wr      (chk_wr),
        .vis_wr      (vis_wr),
        .res_valid   (res_valid),
        .res         (res)
    );

    visit_apb_regs visit_apb_regs_inst (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .clear_start (clear_start),
        .clear_busy  (clear_busy),
        .res_valid   (res_valid),      // Counters watch the result stream
        .res         (res)
    );

endmodule

`default_nettype wire

// ==== rtl/visit_apb_regs.sv ====
`default_nettype none

// APB slave for clear control, busy status and op counters
module visit_apb_regs (
    input  wire                        clk_in,
    input  wire                        rst_in,
    input  wire apb_pkg::apb_req_t     apb_req,
    output apb_pkg::apb_rsp_t          apb_rsp,
    output logic                       clear_start, // Pulse in the ctrl write access cycle
    input  wire                        clear_busy,  // Drain or sweep running
    input  wire                        res_valid,   // Result strobe from the filter
    input  wire visit_pkg::vtx_res_t   res
);

    logic        acc;          // Access phase
    logic        wr_acc;       // Write access
    logic        addr_ok;      // Address is mapped
    logic        addr_ro;      // Address is read-only
    logic [31:0] grant_cnt;    // Granted ops since reset or clear
    logic [31:0] reject_cnt;   // Rejected ops since reset or clear
    logic [31:0] rd_word;      // Decoded read data

    assign acc    = apb_req.psel && apb_req.penable;
    assign wr_acc = acc && apb_req.pwrite;

    // Address decode
    always_comb begin
        addr_ok = 1'b1;
        addr_ro = 1'b1;
        rd_word = '0;
        case (apb_req.paddr)
            apb_pkg::reg_ctrl: begin
                addr_ro = 1'b0;                    // Only writable register, reads 0
            end
            apb_pkg::reg_status: begin
                rd_word[apb_pkg::stat_busy_bit] = clear_busy;
            end
            apb_pkg::reg_grant_cnt: begin
                rd_word = grant_cnt;
            end
            apb_pkg::reg_reject_cnt: begin
                rd_word = reject_cnt;
            end
            default: begin
                addr_ok = 1'b0;                    // Hole in the map
            end
        endcase
    end

    // Zero wait states, error only in the access phase
    assign apb_rsp.prdata  = rd_word;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = acc && (!addr_ok || (apb_req.pwrite && addr_ro));

    assign clear_start = wr_acc && (apb_req.paddr == apb_pkg::reg_ctrl)
                         && apb_req.pwdata[apb_pkg::ctrl_clear_bit];

    // Counters held at zero for the whole clear, drained results included
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            grant_cnt  <= '0;
            reject_cnt <= '0;
        end else if (clear_start || clear_busy) begin
            grant_cnt  <= '0;
            reject_cnt <= '0;
        end else if (res_valid) begin
            if (res.granted) begin
                grant_cnt  <= grant_cnt + 1'b1;
            end else begin
                reject_cnt <= reject_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/visit_filter.sv ====
`default_nettype none

// Grant decision with forwarding from the two most recent write-backs
module visit_filter (
    input  wire                        clk_in,
    input  wire                        rst_in,
    input  wire                        s2_valid,   // Op with read bits ready
    input  wire visit_pkg::vtx_op_t    s2_op,
    input  wire                        s2_checked, // RAM checked bit, may be stale
    input  wire                        s2_visited, // RAM visited bit, may be stale
    output visit_pkg::bit_wr_t         chk_wr,     // Registered checked write-back
    output visit_pkg::bit_wr_t         vis_wr,     // Registered visited write-back
    output logic                       res_valid,
    output visit_pkg::vtx_res_t        res
);

    visit_pkg::bit_wr_t  chk_wr_q2, vis_wr_q2; // Write-backs one cycle older
    visit_pkg::bit_wr_t  chk_nxt, vis_nxt;     // Write-backs of this decision
    logic                chk_hit1, chk_hit2;   // Vertex matches a pending checked write
    logic                vis_hit1, vis_hit2;   // Vertex matches a pending visited write
    logic                checked_eff;          // Checked bit after forwarding
    logic                visited_eff;          // Visited bit after forwarding
    logic                is_discover;
    logic                granted;

    // chk_wr lands in RAM next edge and chk_wr_q2 lands on the read edge
    assign chk_hit1 = chk_wr.en    && (chk_wr.addr    == s2_op.vtx);
    assign chk_hit2 = chk_wr_q2.en && (chk_wr_q2.addr == s2_op.vtx);
    assign vis_hit1 = vis_wr.en    && (vis_wr.addr    == s2_op.vtx);
    assign vis_hit2 = vis_wr_q2.en && (vis_wr_q2.addr == s2_op.vtx);

    // Newest write wins on a match
    always_comb begin
        checked_eff = s2_checked;
        if (chk_hit2) checked_eff = chk_wr_q2.data;
        if (chk_hit1) checked_eff = chk_wr.data;
        visited_eff = s2_visited;
        if (vis_hit2) visited_eff = vis_wr_q2.data;
        if (vis_hit1) visited_eff = vis_wr.data;
    end

    assign is_discover = (s2_op.kind == visit_pkg::op_discover);
    assign granted     = is_discover ? !checked_eff : !visited_eff; // Pass only on first touch

    // Granted op sets its own bit, rejected op writes nothing
    always_comb begin
        chk_nxt      = visit_pkg::bit_wr_idle;
        vis_nxt      = visit_pkg::bit_wr_idle;
        chk_nxt.addr = s2_op.vtx;
        vis_nxt.addr = s2_op.vtx;
        chk_nxt.data = 1'b1;
        vis_nxt.data = 1'b1;
        chk_nxt.en   = s2_valid && granted && is_discover;
        vis_nxt.en   = s2_valid && granted && !is_discover;
    end

    // Decision edge, write-back history and result
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            chk_wr.en    <= 1'b0;
            vis_wr.en    <= 1'b0;
            chk_wr_q2.en <= 1'b0;
            vis_wr_q2.en <= 1'b0;
            res_valid    <= 1'b0;
        end else begin
            chk_wr    <= chk_nxt;             // Shifts every cycle so old entries age out
            vis_wr    <= vis_nxt;
            chk_wr_q2 <= chk_wr;
            vis_wr_q2 <= vis_wr;
            res_valid <= s2_valid;
        end
        res.proc    <= s2_op.proc;            // Tag passes through unchanged
        res.vtx     <= s2_op.vtx;
        res.kind    <= s2_op.kind;
        res.granted <= granted;
    end

endmodule

`default_nettype wire

// ==== rtl/visit_bitmap.sv ====
`default_nettype none

// Checked and visited bitmaps with op carry and clear sweep
module visit_bitmap (
    input  wire                        clk_in,
    input  wire                        rst_in,
    input  wire                        op_valid,    // Op offered
    input  wire visit_pkg::vtx_op_t    op,          // Op payload
    output logic                       op_ready,    // Low while clearing
    input  wire                        clear_start, // One-cycle clear request
    output logic                       clear_busy,  // Drain or sweep running
    input  wire visit_pkg::bit_wr_t    chk_wr,      // Checked write-back from filter
    input  wire visit_pkg::bit_wr_t    vis_wr,      // Visited write-back from filter
    output logic                       s2_valid,    // Op with read bits ready
    output visit_pkg::vtx_op_t         s2_op,
    output logic                       s2_checked,  // Raw checked bit
    output logic                       s2_visited   // Raw visited bit
);

    logic                            s0_valid, s1_valid;     // Stage valids
    visit_pkg::vtx_op_t              s0_op, s1_op;           // Stage payloads
    logic                            sweeping;               // Zero-write phase
    logic [visit_pkg::vtx_bits-1:0]  clr_addr;               // Sweep pointer
    logic                            pipe_empty;             // No op or write-back pending
    visit_pkg::bit_wr_t              sweep_wr;               // Zero write from sweep
    visit_pkg::bit_wr_t              ram_chk_wr, ram_vis_wr; // Muxed RAM write ports

    assign op_ready   = !clear_busy;  // Hold off ops during a clear
    assign pipe_empty = !(s0_valid || s1_valid || s2_valid || chk_wr.en || vis_wr.en);
    assign sweep_wr   = '{en: 1'b1, addr: clr_addr, data: 1'b0};
    assign ram_chk_wr = sweeping ? sweep_wr : chk_wr; // Sweep owns the ports
    assign ram_vis_wr = sweeping ? sweep_wr : vis_wr;

    // Op carry through input register and the two RAM read stages
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s0_valid <= 1'b0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s0_valid <= op_valid && op_ready; // Accept on handshake
            s1_valid <= s0_valid;             // RAM address stage
            s2_valid <= s1_valid;             // RAM data stage
        end
        s0_op <= op;
        s1_op <= s0_op;
        s2_op <= s1_op;
    end

    // Clear control, drain first then sweep every address
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            clear_busy <= 1'b0;
            sweeping   <= 1'b0;
            clr_addr   <= '0;
        end else if (clear_start) begin
            clear_busy <= 1'b1;               // Restart from the drain phase
            sweeping   <= 1'b0;
            clr_addr   <= '0;
        end else if (clear_busy && !sweeping) begin
            sweeping   <= pipe_empty;         // Wait for in-flight write-backs
        end else if (sweeping) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == visit_pkg::vtx_bits'(visit_pkg::vtx_depth - 1)) begin
                sweeping   <= 1'b0;           // Last address written
                clear_busy <= 1'b0;
            end
        end
    end

    bit_ram #(.depth(visit_pkg::vtx_depth)) chk_ram_inst (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .wr      (ram_chk_wr),
        .rd_addr (s0_op.vtx),
        .rd_data (s2_checked)
    );

    bit_ram #(.depth(visit_pkg::vtx_depth)) vis_ram_inst (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .wr      (ram_vis_wr),
        .rd_addr (s0_op.vtx),
        .rd_data (s2_visited)
    );

endmodule

`default_nettype wire

// ==== rtl/bit_ram.sv ====
`default_nettype none

// One-bit simple dual-port block RAM, read-first on collisions
module bit_ram #(
    parameter int unsigned depth = visit_pkg::vtx_depth // Number of one-bit entries
) (
    input  wire                             clk_in,
    input  wire                             rst_in,
    input  wire visit_pkg::bit_wr_t         wr,      // Write port
    input  wire [visit_pkg::vtx_bits-1:0]   rd_addr, // Read address, sampled this edge
    output logic                            rd_data  // Bit valid two edges later
);

    logic mem [0:depth-1];                     // Bit storage, no init
    logic [visit_pkg::vtx_bits-1:0] rd_addr_q; // Address register

    // Write port
    always_ff @(posedge clk_in) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;           // Same-edge read sees old value
        end
    end

    // Read port with address and output registers
    always_ff @(posedge clk_in) begin
        rd_addr_q <= rd_addr;                  // First read stage
        if (rst_in) begin
            rd_data <= 1'b0;                   // Output register reset only
        end else begin
            rd_data <= mem[rd_addr_q];         // Second read stage
        end
    end

endmodule

`default_nettype wire

// ==== rtl/apb_pkg.sv ====
`default_nettype none

package apb_pkg;

    // Bus widths
    localparam int unsigned apb_addr_bits = 8;  // Byte address space of the slave
    localparam int unsigned apb_data_bits = 32; // Data bus width

    // Requester to slave
    typedef struct packed {
        logic                     psel;    // Slave selected
        logic                     penable; // Access phase
        logic                     pwrite;  // 1 write, 0 read
        logic [apb_addr_bits-1:0] paddr;   // Byte address
        logic [apb_data_bits-1:0] pwdata;  // Write data
    } apb_req_t;

    // Slave to requester
    typedef struct packed {
        logic [apb_data_bits-1:0] prdata;  // Read data
        logic                     pready;  // Always high, no wait states
        logic                     pslverr; // Bad address or write to a read-only reg
    } apb_rsp_t;

    // Register map
    localparam logic [apb_addr_bits-1:0] reg_ctrl       = 8'h00; // W, bit 0 starts a clear
    localparam logic [apb_addr_bits-1:0] reg_status     = 8'h04; // R, bit 0 clear busy
    localparam logic [apb_addr_bits-1:0] reg_grant_cnt  = 8'h08; // R, granted ops
    localparam logic [apb_addr_bits-1:0] reg_reject_cnt = 8'h0C; // R, rejected ops

    // Control register fields
    localparam int unsigned ctrl_clear_bit = 0;  // Clear request
    localparam int unsigned stat_busy_bit  = 0;  // Sweep in progress

endpackage

`default_nettype wire

// ==== rtl/visit_pkg.sv ====
`default_nettype none

package visit_pkg;

    // Bitmap geometry
    localparam int unsigned proc_bits = 4;    // Processor tag width
    localparam int unsigned vtx_bits  = 10;   // Vertex index width
    localparam int unsigned vtx_depth = 1024; // Vertices per bitmap

    // Operation kind as sent by a search processor
    typedef enum logic {
        op_discover = 1'b0, // Neighbour found, test and set checked
        op_expand   = 1'b1  // About to pop, test and set visited
    } op_kind_e;

    // Operation entering the filter
    typedef struct packed {
        op_kind_e              kind; // Discover or expand
        logic [proc_bits-1:0]  proc; // Requesting processor
        logic [vtx_bits-1:0]   vtx;  // Target vertex
    } vtx_op_t;

    // Decision returned to the processors
    typedef struct packed {
        logic [proc_bits-1:0]  proc;    // Tag copied from the op
        logic [vtx_bits-1:0]   vtx;     // Vertex copied from the op
        op_kind_e              kind;    // Kind copied from the op
        logic                  granted; // 1 when the bit was still clear
    } vtx_res_t;

    // Write port of one bitmap RAM
    typedef struct packed {
        logic                  en;   // Write strobe
        logic [vtx_bits-1:0]   addr; // Vertex to update
        logic                  data; // New bit value
    } bit_wr_t;

    // Idle write port
    localparam bit_wr_t bit_wr_idle = '{en: 1'b0, addr: '0, data: 1'b0};

endpackage

`default_nettype wire
